//--- logic/ex_pkg.sv
package ex_pkg;

  ////////////////////
  // widths
  ////////////////////

  typedef logic [31:0] xlen_t;      // one register word
  typedef logic [63:0] prod_t;      // full multiplier product
  typedef logic [4:0]  reg_idx_t;   // destination register number
  typedef logic [14:0] aluop_t;     // one-hot operation

  ////////////////////
  // operation bit positions
  ////////////////////

  localparam int ALUOP_ADD   = 0;
  localparam int ALUOP_SUB   = 1;
  localparam int ALUOP_SLL   = 2;
  localparam int ALUOP_SRL   = 3;
  localparam int ALUOP_SRA   = 4;
  localparam int ALUOP_SLT   = 5;
  localparam int ALUOP_SLTU  = 6;
  localparam int ALUOP_OR    = 7;
  localparam int ALUOP_XOR   = 8;
  localparam int ALUOP_AND   = 9;
  localparam int ALUOP_MUL   = 10;  // low half, signed
  localparam int ALUOP_MULH  = 11;  // high half, signed x signed
  localparam int ALUOP_MULU  = 12;  // high half, unsigned x unsigned
  localparam int ALUOP_MULSU = 13;  // high half, signed x unsigned
  localparam int ALUOP_LINK  = 14;

  // operand source selects
  localparam logic SRC1_FROM_REG = 1'b0;
  localparam logic SRC1_FROM_PC  = 1'b1;
  localparam logic SRC2_FROM_REG = 1'b0;
  localparam logic SRC2_FROM_IMM = 1'b1;

  ////////////////////
  // records
  ////////////////////

  typedef struct packed {
    xlen_t    pc;
    aluop_t   aluop;
    logic     alusrc1;
    logic     alusrc2;
    xlen_t    rs1;
    xlen_t    rs2;
    xlen_t    imm;
    xlen_t    link_addr;
    reg_idx_t rd;
  } ex_req_t;

  typedef struct packed {
    reg_idx_t rd;
    xlen_t    wreg_data;  // register write value
    xlen_t    wdata;      // store data, always rs2
  } ex_res_t;

  ////////////////////
  // depths and counts
  ////////////////////

  localparam int REQ_DEPTH   = 4;   // also the sender's starting credits
  localparam int RES_CREDITS = 2;
  localparam int MUL_ITERS   = 32;

  localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
  localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);
  localparam int CRED_W    = $clog2(RES_CREDITS + 1);
  localparam int MUL_CNT_W = $clog2(MUL_ITERS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MUL,
    ST_MUL_DONE
  } ex_state_e;

endpackage

//--- logic/ex_req_fifo.sv
`timescale 1ns/1ps

module ex_req_fifo (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            push_i,
  input  ex_pkg::ex_req_t push_data_i,
  input  logic            pop_i,
  output ex_pkg::ex_req_t head_o,
  output logic            empty_o,
  output logic            credit_o
);

  ex_pkg::ex_req_t mem [ex_pkg::REQ_DEPTH];

  logic [ex_pkg::REQ_PTR_W-1:0] wr_ptr_q;
  logic [ex_pkg::REQ_PTR_W-1:0] rd_ptr_q;
  logic [ex_pkg::REQ_CNT_W-1:0] count_q;
  logic                         full;
  logic                         do_push;
  logic                         do_pop;

  assign full     = (count_q == ex_pkg::REQ_CNT_W'(ex_pkg::REQ_DEPTH));
  assign empty_o  = (count_q == '0);
  assign do_push  = push_i && !full;   // drop without a credit
  assign do_pop   = pop_i && !empty_o;
  assign credit_o = do_pop;            // freed slot goes back upstream
  assign head_o   = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ex_pkg::REQ_PTR_W'(ex_pkg::REQ_DEPTH - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ex_pkg::REQ_PTR_W'(ex_pkg::REQ_DEPTH - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- logic/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::ex_req_t req_i,
  output ex_pkg::xlen_t   result_o,
  output ex_pkg::xlen_t   src1_o,
  output ex_pkg::xlen_t   src2_o,
  output logic            is_mul_o
);

  ex_pkg::xlen_t  src1;
  ex_pkg::xlen_t  src2;
  ex_pkg::aluop_t op;
  logic [4:0]     shamt;

  assign op    = req_i.aluop;
  assign shamt = src2[4:0];   // low five bits only

  ////////////////////
  // operand select
  ////////////////////

  always_comb begin
    if (req_i.alusrc1 == ex_pkg::SRC1_FROM_REG) begin
      src1 = req_i.rs1;
    end else begin
      src1 = req_i.pc;
    end
  end

  always_comb begin
    if (req_i.alusrc2 == ex_pkg::SRC2_FROM_REG) begin
      src2 = req_i.rs2;
    end else begin
      src2 = req_i.imm;
    end
  end

  assign src1_o = src1;
  assign src2_o = src2;

  assign is_mul_o = op[ex_pkg::ALUOP_MUL]  | op[ex_pkg::ALUOP_MULH] |
                    op[ex_pkg::ALUOP_MULU] | op[ex_pkg::ALUOP_MULSU];

  ////////////////////
  // single-cycle ops
  ////////////////////

  always_comb begin
    case (1'b1)
      op[ex_pkg::ALUOP_ADD]: begin
        result_o = src1 + src2;
      end
      op[ex_pkg::ALUOP_SUB]: begin
        result_o = src1 - src2;
      end
      op[ex_pkg::ALUOP_SLL]: begin
        result_o = src1 << shamt;
      end
      op[ex_pkg::ALUOP_SRL]: begin
        result_o = src1 >> shamt;
      end
      op[ex_pkg::ALUOP_SRA]: begin
        result_o = $signed(src1) >>> shamt;
      end
      op[ex_pkg::ALUOP_SLT]: begin
        result_o = ($signed(src1) < $signed(src2)) ? 32'd1 : 32'd0;
      end
      op[ex_pkg::ALUOP_SLTU]: begin
        result_o = (src1 < src2) ? 32'd1 : 32'd0;
      end
      op[ex_pkg::ALUOP_OR]: begin
        result_o = src1 | src2;
      end
      op[ex_pkg::ALUOP_XOR]: begin
        result_o = src1 ^ src2;
      end
      op[ex_pkg::ALUOP_AND]: begin
        result_o = src1 & src2;
      end
      op[ex_pkg::ALUOP_LINK]: begin
        result_o = req_i.link_addr;   // return address passthrough
      end
      default: result_o = '0;         // multiplies and no-op
    endcase
  end

endmodule

//--- logic/ex_mul.sv
`timescale 1ns/1ps

module ex_mul (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           start_i,
  input  ex_pkg::aluop_t aluop_i,
  input  ex_pkg::xlen_t  src1_i,
  input  ex_pkg::xlen_t  src2_i,
  input  logic           step_i,
  output ex_pkg::xlen_t  result_o
);

  logic          sgn_a;
  logic          sgn_b;
  logic          neg_a;
  logic          neg_b;
  ex_pkg::xlen_t mag_a;
  ex_pkg::xlen_t mag_b;
  ex_pkg::prod_t acc_q;
  ex_pkg::prod_t mcand_q;     // shifts left each step
  ex_pkg::xlen_t mplier_q;    // shifts right each step
  logic          neg_q;
  logic          hi_q;
  ex_pkg::prod_t prod;

  // operand signedness per form
  assign sgn_a = aluop_i[ex_pkg::ALUOP_MUL] | aluop_i[ex_pkg::ALUOP_MULH] |
                 aluop_i[ex_pkg::ALUOP_MULSU];
  assign sgn_b = aluop_i[ex_pkg::ALUOP_MUL] | aluop_i[ex_pkg::ALUOP_MULH];

  assign neg_a = sgn_a & src1_i[31];
  assign neg_b = sgn_b & src2_i[31];
  assign mag_a = neg_a ? (~src1_i) + ex_pkg::xlen_t'(1) : src1_i;
  assign mag_b = neg_b ? (~src2_i) + ex_pkg::xlen_t'(1) : src2_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_q <= '0;
      neg_q <= 1'b0;
      hi_q  <= 1'b0;
    end else if (start_i) begin
      acc_q <= '0;
      neg_q <= neg_a ^ neg_b;
      hi_q  <= !aluop_i[ex_pkg::ALUOP_MUL];
    end else if (step_i && mplier_q[0]) begin
      acc_q <= acc_q + mcand_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      mcand_q  <= {32'd0, mag_a};
      mplier_q <= mag_b;
    end else if (step_i) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // restore the sign of the magnitude product
  assign prod = neg_q ? (~acc_q) + ex_pkg::prod_t'(1) : acc_q;

  assign result_o = hi_q ? prod[63:32] : prod[31:0];

endmodule

//--- logic/ex_cycle_counter.sv
`timescale 1ns/1ps

module ex_cycle_counter (
  input  logic clk_i,
  input  logic reset_i,
  input  logic load_i,
  output logic active_o,
  output logic last_o
);

  logic [ex_pkg::MUL_CNT_W-1:0] cnt_q;
  logic                         active_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
    end else if (load_i) begin
      cnt_q    <= ex_pkg::MUL_CNT_W'(ex_pkg::MUL_ITERS - 1);
      active_q <= 1'b1;
    end else if (active_q) begin
      if (cnt_q == '0) begin
        active_q <= 1'b0;   // final step done
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign active_o = active_q;
  assign last_o   = active_q && (cnt_q == '0);

endmodule

//--- logic/ex_ctrl.sv
`timescale 1ns/1ps

module ex_ctrl (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            empty_i,
  input  ex_pkg::ex_req_t head_i,
  output logic            pop_o,
  output ex_pkg::ex_req_t held_o,
  input  ex_pkg::xlen_t   alu_result_i,
  input  logic            is_mul_i,
  input  ex_pkg::xlen_t   mul_result_i,
  output logic            mul_start_o,
  output logic            cnt_load_o,
  input  logic            cnt_last_i,
  output logic            res_valid_o,
  output ex_pkg::ex_res_t res_o,
  input  logic            res_credit_i
);

  ex_pkg::ex_state_e          state_q;
  ex_pkg::ex_req_t            held_q;
  logic                       held_valid_q;
  logic [ex_pkg::CRED_W-1:0]  cred_q;
  logic                       res_valid_q;
  ex_pkg::ex_res_t            res_q;
  logic                       res_load;
  ex_pkg::xlen_t              res_data;

  ////////////////////
  // strobes
  ////////////////////

  assign pop_o = (state_q == ex_pkg::ST_IDLE) && !held_valid_q && !empty_i &&
                 (cred_q != '0);
  assign mul_start_o = (state_q == ex_pkg::ST_IDLE) && held_valid_q && is_mul_i;
  assign cnt_load_o  = mul_start_o;

  assign res_load = ((state_q == ex_pkg::ST_IDLE) && held_valid_q && !is_mul_i) ||
                    (state_q == ex_pkg::ST_MUL_DONE);
  assign res_data = (state_q == ex_pkg::ST_MUL_DONE) ? mul_result_i : alu_result_i;

  ////////////////////
  // state and credits
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= ex_pkg::ST_IDLE;
      held_valid_q <= 1'b0;
      cred_q       <= ex_pkg::CRED_W'(ex_pkg::RES_CREDITS);
      res_valid_q  <= 1'b0;
    end else begin
      case (state_q)
        ex_pkg::ST_IDLE:     if (mul_start_o) state_q <= ex_pkg::ST_MUL;
        ex_pkg::ST_MUL:      if (cnt_last_i) state_q <= ex_pkg::ST_MUL_DONE;
        ex_pkg::ST_MUL_DONE: state_q <= ex_pkg::ST_IDLE;
        default:             state_q <= ex_pkg::ST_IDLE;
      endcase
      if (pop_o) begin
        held_valid_q <= 1'b1;
      end else if (res_load) begin
        held_valid_q <= 1'b0;
      end
      case ({res_load, res_credit_i})
        2'b10:   cred_q <= cred_q - 1'b1;   // spent on emit
        2'b01:   cred_q <= cred_q + 1'b1;
        default: cred_q <= cred_q;
      endcase
      res_valid_q <= res_load;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      held_q <= head_i;
    end
    if (res_load) begin
      res_q.rd        <= held_q.rd;
      res_q.wreg_data <= res_data;
      res_q.wdata     <= held_q.rs2;
    end
  end

  assign held_o      = held_q;
  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

endmodule

//--- logic/ex_unit.sv
`timescale 1ns/1ps

module ex_unit (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            req_valid_i,
  input  ex_pkg::ex_req_t req_i,
  output logic            req_credit_o,
  output logic            res_valid_o,
  output ex_pkg::ex_res_t res_o,
  input  logic            res_credit_i
);

  ex_pkg::ex_req_t head;
  ex_pkg::ex_req_t held;
  logic            empty;
  logic            pop;
  ex_pkg::xlen_t   alu_result;
  ex_pkg::xlen_t   src1;
  ex_pkg::xlen_t   src2;
  logic            is_mul;
  ex_pkg::xlen_t   mul_result;
  logic            mul_start;
  logic            cnt_load;
  logic            cnt_active;
  logic            cnt_last;

  ex_req_fifo i_req_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (req_valid_i),
    .push_data_i (req_i),
    .pop_i       (pop),
    .head_o      (head),
    .empty_o     (empty),
    .credit_o    (req_credit_o)
  );

  ex_ctrl i_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .empty_i      (empty),
    .head_i       (head),
    .pop_o        (pop),
    .held_o       (held),
    .alu_result_i (alu_result),
    .is_mul_i     (is_mul),
    .mul_result_i (mul_result),
    .mul_start_o  (mul_start),
    .cnt_load_o   (cnt_load),
    .cnt_last_i   (cnt_last),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o),
    .res_credit_i (res_credit_i)
  );

  ex_alu i_alu (
    .req_i    (held),
    .result_o (alu_result),
    .src1_o   (src1),
    .src2_o   (src2),
    .is_mul_o (is_mul)
  );

  ex_cycle_counter i_cycle_counter (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .load_i   (cnt_load),
    .active_o (cnt_active),
    .last_o   (cnt_last)
  );

  ex_mul i_mul (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (mul_start),
    .aluop_i  (held.aluop),
    .src1_i   (src1),
    .src2_i   (src2),
    .step_i   (cnt_active),   // one shift-add per active cycle
    .result_o (mul_result)
  );

endmodule

//--- verif/ex_unit_tests.svh
// sends one record once a sender credit is free
task automatic send_req(ex_pkg::ex_req_t r);
  ex_pkg::ex_res_t e;
  int              waited;
  e.rd        = r.rd;
  e.wreg_data = model_wreg(r);
  e.wdata     = r.rs2;
  waited      = 0;
  @(posedge clk_i);
  while (sender_credits - int'(req_valid_i) <= 0 && waited < TIMEOUT) begin
    req_valid_i <= 1'b0;
    waited++;
    @(posedge clk_i);
  end
  if (sender_credits - int'(req_valid_i) <= 0) begin
    fail_run("timeout waiting for an input credit");
  end else begin
    req_valid_i <= 1'b1;
    req_i       <= r;
    exp_q.push_back(e);
  end
endtask

task automatic end_burst();
  @(posedge clk_i);
  req_valid_i <= 1'b0;
endtask

function automatic ex_pkg::ex_req_t make_req(int op, logic s1, logic s2,
                                             ex_pkg::xlen_t a, ex_pkg::xlen_t b);
  ex_pkg::ex_req_t r;
  r.pc        = $urandom & 32'hFFFF_FFFC;
  r.aluop     = ex_pkg::aluop_t'(1) << op;
  r.alusrc1   = s1;
  r.alusrc2   = s2;
  r.rs1       = a;
  r.rs2       = b;
  r.imm       = $urandom;
  r.link_addr = r.pc + 32'd4;
  r.rd        = ex_pkg::reg_idx_t'($urandom);
  return r;
endfunction

task automatic check_results(string test, int n);
  ex_pkg::ex_res_t got;
  ex_pkg::ex_res_t exp;
  int              waited;
  waited = 0;
  while (res_q.size() < n && waited < TIMEOUT) begin
    @(negedge clk_i);
    waited++;
  end
  if (res_q.size() < n) begin
    fail_run($sformatf("timeout waiting for %0d results in %s", n, test));
  end else begin
    for (int i = 0; i < n; i++) begin
      got = res_q.pop_front();
      exp = exp_q.pop_front();
      check_equal(test, "rd", ex_pkg::xlen_t'(exp.rd), ex_pkg::xlen_t'(got.rd));
      check_equal(test, "wreg_data", exp.wreg_data, got.wreg_data);
      check_equal(test, "wdata", exp.wdata, got.wdata);
    end
  end
endtask

// every popped record returns its input credit
task automatic check_credits(string test);
  int waited;
  waited = 0;
  while (sender_credits != ex_pkg::REQ_DEPTH && waited < TIMEOUT) begin
    @(negedge clk_i);
    waited++;
  end
  assert (sender_credits == ex_pkg::REQ_DEPTH) else begin
    fail_run($sformatf("input credits never came back after %s", test));
  end
endtask

task automatic single_cycle_ops();
  int            ops[11];
  ex_pkg::xlen_t av[4];
  ex_pkg::xlen_t bv[4];
  int            n;
  ops = '{ex_pkg::ALUOP_ADD, ex_pkg::ALUOP_SUB, ex_pkg::ALUOP_SLL, ex_pkg::ALUOP_SRL,
          ex_pkg::ALUOP_SRA, ex_pkg::ALUOP_SLT, ex_pkg::ALUOP_SLTU, ex_pkg::ALUOP_OR,
          ex_pkg::ALUOP_XOR, ex_pkg::ALUOP_AND, ex_pkg::ALUOP_LINK};
  av  = '{32'h0000_0005, 32'h8000_0010, 32'hFFFF_FFF0, 32'h1234_5678};
  bv  = '{32'h0000_0003, 32'h0000_0004, 32'h7FFF_0001, 32'h8765_4321};
  n   = 0;
  foreach (ops[i]) begin
    for (int sel = 0; sel < 4; sel++) begin  // all four source selects
      for (int v = 0; v < 4; v++) begin
        send_req(make_req(ops[i], sel[1], sel[0], av[v], bv[v]));
        n++;
      end
    end
  end
  end_burst();
  check_results("single_cycle_ops", n);
endtask

task automatic multiply_forms();
  int            ops[4];
  ex_pkg::xlen_t edges[4];
  ex_pkg::xlen_t a;
  ex_pkg::xlen_t b;
  int            n;
  ops   = '{ex_pkg::ALUOP_MUL, ex_pkg::ALUOP_MULH, ex_pkg::ALUOP_MULU, ex_pkg::ALUOP_MULSU};
  edges = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 32'h7FFF_FFFF};
  n     = 0;
  foreach (ops[k]) begin
    for (int i = 0; i < 40; i++) begin
      if (i < 16) begin  // every edge pair first
        a = edges[i / 4];
        b = edges[i % 4];
      end else begin
        a = $urandom;
        b = $urandom;
      end
      send_req(make_req(ops[k], ex_pkg::SRC1_FROM_REG, ex_pkg::SRC2_FROM_REG, a, b));
      n++;
    end
  end
  end_burst();
  check_results("multiply_forms", n);
endtask

task automatic mixed_stream();
  for (int i = 0; i < 24; i++) begin
    send_req(make_req(int'($urandom_range(14, 0)), 1'($urandom_range(1, 0)),
                      1'($urandom_range(1, 0)), $urandom, $urandom));
  end
  end_burst();
  check_results("mixed_stream", 24);
endtask

task automatic back_pressure();
  int total;
  total = ex_pkg::REQ_DEPTH + ex_pkg::RES_CREDITS;
  @(posedge clk_i);
  hold_credits <= 1'b1;
  for (int i = 0; i < total; i++) begin
    send_req(make_req(ex_pkg::ALUOP_XOR, ex_pkg::SRC1_FROM_REG, ex_pkg::SRC2_FROM_IMM,
                      $urandom, $urandom));
  end
  end_burst();
  repeat (300) @(negedge clk_i);
  check_equal("back_pressure", "results in window", ex_pkg::xlen_t'(ex_pkg::RES_CREDITS),
              ex_pkg::xlen_t'(res_q.size()));
  @(posedge clk_i);
  hold_credits <= 1'b0;
  check_results("back_pressure", total);
endtask

//--- verif/ex_unit_tb.sv
`timescale 1ns/1ps

module ex_unit_tb;

  localparam int TIMEOUT = 2000;

  logic            clk_i        = 1'b0;
  logic            reset_i      = 1'b1;
  logic            req_valid_i  = 1'b0;
  ex_pkg::ex_req_t req_i        = '0;
  logic            req_credit_o;
  logic            res_valid_o;
  ex_pkg::ex_res_t res_o;
  logic            res_credit_i = 1'b0;

  ex_pkg::ex_res_t res_q[$];      // results seen at the output
  ex_pkg::ex_res_t exp_q[$];      // model results in issue order
  int              sender_credits;
  int              owed;          // output credits not yet returned
  logic            hold_credits = 1'b0;

  ex_unit i_ex_unit (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_credit_o (req_credit_o),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o),
    .res_credit_i (res_credit_i)
  );

  always #50 clk_i = ~clk_i;

  ////////////////////
  // reference model
  ////////////////////

  function automatic ex_pkg::xlen_t model_wreg(ex_pkg::ex_req_t r);
    ex_pkg::xlen_t a;
    ex_pkg::xlen_t b;
    ex_pkg::prod_t sa;
    ex_pkg::prod_t p_ss;
    ex_pkg::prod_t p_uu;
    ex_pkg::prod_t p_su;
    int            sh;
    a    = (r.alusrc1 == ex_pkg::SRC1_FROM_PC) ? r.pc : r.rs1;
    b    = (r.alusrc2 == ex_pkg::SRC2_FROM_IMM) ? r.imm : r.rs2;
    sh   = int'(b[4:0]);
    sa   = {{32{a[31]}}, a};
    p_ss = sa * {{32{b[31]}}, b};   // modulo 2^64 equals the signed product
    p_uu = {32'd0, a} * {32'd0, b};
    p_su = sa * {32'd0, b};
    if (r.aluop[ex_pkg::ALUOP_ADD])   return a + b;
    if (r.aluop[ex_pkg::ALUOP_SUB])   return a - b;
    if (r.aluop[ex_pkg::ALUOP_SLL])   return a << sh;
    if (r.aluop[ex_pkg::ALUOP_SRL])   return a >> sh;
    if (r.aluop[ex_pkg::ALUOP_SRA])   return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
    if (r.aluop[ex_pkg::ALUOP_SLT])   return {31'd0, $signed(a) < $signed(b)};
    if (r.aluop[ex_pkg::ALUOP_SLTU])  return {31'd0, a < b};
    if (r.aluop[ex_pkg::ALUOP_OR])    return a | b;
    if (r.aluop[ex_pkg::ALUOP_XOR])   return a ^ b;
    if (r.aluop[ex_pkg::ALUOP_AND])   return a & b;
    if (r.aluop[ex_pkg::ALUOP_MUL])   return p_ss[31:0];
    if (r.aluop[ex_pkg::ALUOP_MULH])  return p_ss[63:32];
    if (r.aluop[ex_pkg::ALUOP_MULU])  return p_uu[63:32];
    if (r.aluop[ex_pkg::ALUOP_MULSU]) return p_su[63:32];
    if (r.aluop[ex_pkg::ALUOP_LINK])  return r.link_addr;
    return '0;
  endfunction

  ////////////////////
  // monitor and credits
  ////////////////////

  always @(posedge clk_i) begin
    if (reset_i) begin
      owed = 0;
      res_credit_i <= 1'b0;
    end else begin
      if (res_valid_o) begin
        res_q.push_back(res_o);
        owed = owed + 1;
      end
      if (!hold_credits && owed > 0) begin
        res_credit_i <= 1'b1;
        owed = owed - 1;
      end else begin
        res_credit_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      sender_credits <= ex_pkg::REQ_DEPTH;
    end else begin
      assert (sender_credits + int'(req_credit_o) - int'(req_valid_i) <= ex_pkg::REQ_DEPTH)
      else begin
        fail_run("input credit returned for a record that was never sent");
      end
      sender_credits <= sender_credits + int'(req_credit_o) - int'(req_valid_i);
    end
  end

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(string test, string field, ex_pkg::xlen_t exp,
                             ex_pkg::xlen_t act);
    assert (act === exp) else begin
      fail_run($sformatf("mismatch %s %s: expected %h actual %h", test, field, exp, act));
    end
  endtask

  `include "ex_unit_tests.svh"

  initial begin
    void'($urandom(32'h2113151d));
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    assert (res_valid_o == 1'b0 && req_credit_o == 1'b0) else begin
      fail_run("res_valid_o or req_credit_o is high after reset");
    end
    single_cycle_ops();
    check_credits("single_cycle_ops");
    multiply_forms();
    check_credits("multiply_forms");
    mixed_stream();
    check_credits("mixed_stream");
    back_pressure();
    check_credits("back_pressure");
    if (res_q.size() == 0 && exp_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      fail_run("results left over at the end of the run");
    end
  end

endmodule

//--- project.f
+incdir+verif
logic/ex_pkg.sv
logic/ex_req_fifo.sv
logic/ex_alu.sv
logic/ex_mul.sv
logic/ex_cycle_counter.sv
logic/ex_ctrl.sv
logic/ex_unit.sv
verif/ex_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ex_unit_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
